/* hdl/sram_ctrl_pkg.sv */
// SRAM controller widths, microcode partition tag and the two-view SRAM address union
package sram_ctrl_pkg;

   // SRAM geometry, two 16-bit halves side by side
   localparam int SRAM_AW     = 18;
   localparam int HALF_W      = 16;
   localparam int WORD_W      = 2 * HALF_W;

   // client word and address widths
   localparam int MCR_W       = 49;
   localparam int MCR_AW      = 14;
   localparam int DATA_WIN_AW = 17;

   // partition map, top three address bits
   //   00x, 01x  data memory
   //   10x       microcode
   localparam logic [2:0] MCR_TAG = 3'b100;

   // microcode view, half_lo is 0 for the high half
   typedef struct packed {
      logic [2:0]        tag;
      logic [MCR_AW-1:0] addr;
      logic              half_lo;
   } mcr_addr_t;

   // data memory view, region bit stays zero
   typedef struct packed {
      logic                   region;
      logic [DATA_WIN_AW-1:0] offset;
   } data_addr_t;

   typedef union packed {
      mcr_addr_t  mcr;
      data_addr_t data;
   } sram_addr_u;

endpackage

/* hdl/mcr_port.sv */
// microcode client port: request handshake, two-half access sequencing, 49-bit read assembly
`timescale 1ns/100ps

module mcr_port (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             i_mcr_rd_req,
   input  logic                             i_mcr_wr_req,
   input  logic [sram_ctrl_pkg::MCR_AW-1:0] i_mcr_addr,
   input  logic [sram_ctrl_pkg::MCR_W-1:0]  i_mcr_wdata,
   input  logic                             i_acc_done,
   input  logic [sram_ctrl_pkg::WORD_W-1:0] i_acc_rdata,
   output logic [sram_ctrl_pkg::MCR_W-1:0]  o_mcr_rdata,
   output logic                             o_mcr_ready,
   output logic                             o_mcr_done,
   output logic                             o_acc_req,
   output logic                             o_acc_write,
   output logic [sram_ctrl_pkg::MCR_AW-1:0] o_acc_addr,
   output logic [sram_ctrl_pkg::MCR_W-1:0]  o_acc_wdata
);
   import sram_ctrl_pkg::*;

   localparam logic [2:0] ST_IDLE = 3'b001;
   localparam logic [2:0] ST_PEND = 3'b010;
   localparam logic [2:0] ST_WREL = 3'b100;

   logic [2:0]        state;
   logic              write_q;
   logic              half_q;
   logic              any_req;
   logic              release_req;
   logic [MCR_AW-1:0] addr_q;
   logic [MCR_W-1:0]  wdata_q;
   logic [MCR_W-1:0]  rdata_q;

   assign any_req     = i_mcr_rd_req | i_mcr_wr_req;
   assign release_req = write_q ? ~i_mcr_wr_req : ~i_mcr_rd_req;

   // --------------------------------------------------------------------------
   // handshake FSM, half_q counts the two SRAM accesses
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= ST_IDLE;
         write_q <= 1'b0;
         half_q  <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (any_req)
               begin
                  state   <= ST_PEND;
                  write_q <= i_mcr_wr_req;
                  half_q  <= 1'b0;
               end
            ST_PEND:
               if (i_acc_done)
               begin
                  half_q <= ~half_q;
                  if (half_q)
                     state <= ST_WREL;
               end
            ST_WREL:
               if (release_req)
                  state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // latched request fields and the assembled read word
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && any_req)
      begin
         addr_q  <= i_mcr_addr;
         wdata_q <= i_mcr_wdata;
      end
      if (state == ST_PEND && i_acc_done && !write_q)
      begin
         // high half brings bit 48 and bits 47..32
         if (half_q)
            rdata_q[WORD_W-1:0] <= i_acc_rdata;
         else
            rdata_q[MCR_W-1:WORD_W] <= i_acc_rdata[MCR_W-WORD_W-1:0];
      end
   end

   assign o_acc_req   = (state == ST_PEND);
   assign o_acc_write = write_q;
   assign o_acc_addr  = addr_q;
   assign o_acc_wdata = wdata_q;
   assign o_mcr_rdata = rdata_q;
   assign o_mcr_ready = (state == ST_WREL) && !write_q;
   assign o_mcr_done  = (state == ST_WREL) && write_q;

endmodule

/* hdl/data_port.sv */
// data memory client port: request handshake, window check, all-ones read outside the window
`timescale 1ns/100ps

module data_port #(
   parameter int DATA_AW = 22
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  i_data_rd_req,
   input  logic                                  i_data_wr_req,
   input  logic [DATA_AW-1:0]                    i_data_addr,
   input  logic [sram_ctrl_pkg::WORD_W-1:0]      i_data_wdata,
   input  logic                                  i_acc_done,
   input  logic [sram_ctrl_pkg::WORD_W-1:0]      i_acc_rdata,
   output logic [sram_ctrl_pkg::WORD_W-1:0]      o_data_rdata,
   output logic                                  o_data_ready,
   output logic                                  o_data_done,
   output logic                                  o_acc_req,
   output logic                                  o_acc_write,
   output logic [sram_ctrl_pkg::DATA_WIN_AW-1:0] o_acc_offset,
   output logic [sram_ctrl_pkg::WORD_W-1:0]      o_acc_wdata
);
   import sram_ctrl_pkg::*;

   localparam logic [2:0] ST_IDLE = 3'b001;
   localparam logic [2:0] ST_PEND = 3'b010;
   localparam logic [2:0] ST_WREL = 3'b100;

   logic [2:0]         state;
   logic               write_q;
   logic               any_req;
   logic               release_req;
   logic               out_of_win;
   logic [DATA_AW-1:0] addr_q;
   logic [WORD_W-1:0]  wdata_q;
   logic [WORD_W-1:0]  rdata_q;

   assign any_req     = i_data_rd_req | i_data_wr_req;
   assign release_req = write_q ? ~i_data_wr_req : ~i_data_rd_req;

   // address bits above the window select nothing in the SRAM
   assign out_of_win  = |addr_q[DATA_AW-1:DATA_WIN_AW];

   // --------------------------------------------------------------------------
   // handshake FSM, one SRAM access per transaction
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= ST_IDLE;
         write_q <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
               if (any_req)
               begin
                  state   <= ST_PEND;
                  write_q <= i_data_wr_req;
               end
            ST_PEND:
               if (i_acc_done)
                  state <= ST_WREL;
            ST_WREL:
               if (release_req)
                  state <= ST_IDLE;
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && any_req)
      begin
         addr_q  <= i_data_addr;
         wdata_q <= i_data_wdata;
      end
      // access still runs, only the returned word is replaced
      if (state == ST_PEND && i_acc_done && !write_q)
         rdata_q <= out_of_win ? '1 : i_acc_rdata;
   end

   assign o_acc_req    = (state == ST_PEND);
   assign o_acc_write  = write_q;
   assign o_acc_offset = addr_q[DATA_WIN_AW-1:0];
   assign o_acc_wdata  = wdata_q;
   assign o_data_rdata = rdata_q;
   assign o_data_ready = (state == ST_WREL) && !write_q;
   assign o_data_done  = (state == ST_WREL) && write_q;

endmodule

/* hdl/sram_arbiter.sv */
// SRAM arbiter: fixed priority grant, microcode half ordering, address and write data forming
`timescale 1ns/100ps

module sram_arbiter (
   input  logic                                  clk,
   input  logic                                  reset,
   // microcode side
   input  logic                                  i_mcr_acc_req,
   input  logic                                  i_mcr_acc_write,
   input  logic [sram_ctrl_pkg::MCR_AW-1:0]      i_mcr_acc_addr,
   input  logic [sram_ctrl_pkg::MCR_W-1:0]       i_mcr_acc_wdata,
   output logic                                  o_mcr_acc_done,
   // data memory side
   input  logic                                  i_data_acc_req,
   input  logic                                  i_data_acc_write,
   input  logic [sram_ctrl_pkg::DATA_WIN_AW-1:0] i_data_acc_offset,
   input  logic [sram_ctrl_pkg::WORD_W-1:0]      i_data_acc_wdata,
   output logic                                  o_data_acc_done,
   output logic [sram_ctrl_pkg::WORD_W-1:0]      o_acc_rdata,
   // sequencer
   output logic                                  o_start,
   output sram_ctrl_pkg::sram_addr_u             o_addr,
   output logic                                  o_write,
   output logic [sram_ctrl_pkg::WORD_W-1:0]      o_wdata,
   input  logic                                  i_done,
   input  logic [sram_ctrl_pkg::WORD_W-1:0]      i_rdata
);
   import sram_ctrl_pkg::*;

   logic              busy;
   logic              sel_mcr;
   logic              mcr_half;
   logic              grant;
   logic              nxt_write;
   logic [WORD_W-1:0] nxt_wdata;
   sram_addr_u        nxt_addr;

   // microcode wins, and keeps its request up across both halves
   assign grant = !busy && (i_mcr_acc_req || i_data_acc_req);

   always_comb
   begin
      nxt_addr = '0;
      if (i_mcr_acc_req)
      begin
         nxt_addr.mcr.tag     = MCR_TAG;
         nxt_addr.mcr.addr    = i_mcr_acc_addr;
         nxt_addr.mcr.half_lo = mcr_half;
         nxt_write            = i_mcr_acc_write;
         // high half is {15'b0, bit 48} in half 1 and bits 47..32 in half 2
         if (mcr_half)
            nxt_wdata = i_mcr_acc_wdata[WORD_W-1:0];
         else
            nxt_wdata = {{(2*WORD_W-MCR_W){1'b0}}, i_mcr_acc_wdata[MCR_W-1:WORD_W]};
      end
      else
      begin
         nxt_addr.data.region = 1'b0;
         nxt_addr.data.offset = i_data_acc_offset;
         nxt_write            = i_data_acc_write;
         nxt_wdata            = i_data_acc_wdata;
      end
   end

   // --------------------------------------------------------------------------
   // one access outstanding at a time, idle cycle after each done
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy     <= 1'b0;
         o_start  <= 1'b0;
         sel_mcr  <= 1'b0;
         mcr_half <= 1'b0;
      end
      else
      begin
         o_start <= grant;
         if (grant)
         begin
            busy    <= 1'b1;
            sel_mcr <= i_mcr_acc_req;
         end
         else if (i_done)
            busy <= 1'b0;
         if (i_done && sel_mcr)
            mcr_half <= ~mcr_half;
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant)
      begin
         o_addr  <= nxt_addr;
         o_write <= nxt_write;
         o_wdata <= nxt_wdata;
      end
   end

   // done goes back to whichever client was served
   assign o_mcr_acc_done  = i_done & sel_mcr;
   assign o_data_acc_done = i_done & ~sel_mcr;
   assign o_acc_rdata     = i_rdata;

endmodule

/* hdl/sram_sequencer.sv */
// SRAM sequencer: four-phase registered pin timing and read data capture
`timescale 1ns/100ps

module sram_sequencer (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              i_start,
   input  sram_ctrl_pkg::sram_addr_u         i_addr,
   input  logic                              i_write,
   input  logic [sram_ctrl_pkg::WORD_W-1:0]  i_wdata,
   input  logic [sram_ctrl_pkg::HALF_W-1:0]  i_sram1_in,
   input  logic [sram_ctrl_pkg::HALF_W-1:0]  i_sram2_in,
   output logic                              o_done,
   output logic [sram_ctrl_pkg::WORD_W-1:0]  o_rdata,
   output logic [sram_ctrl_pkg::SRAM_AW-1:0] o_sram_a,
   output logic                              o_sram_oe_n,
   output logic                              o_sram_we_n,
   output logic                              o_sram_ce_n,
   output logic [sram_ctrl_pkg::HALF_W-1:0]  o_sram1_out,
   output logic [sram_ctrl_pkg::HALF_W-1:0]  o_sram2_out
);
   import sram_ctrl_pkg::*;

   // one-hot phase, bit 0 is the first cycle with pins driven
   logic [3:0]        phase;
   logic [WORD_W-1:0] rdata_q;

   // --------------------------------------------------------------------------
   // control pins, active from the cycle after start through done
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase       <= 4'b0000;
         o_sram_ce_n <= 1'b1;
         o_sram_oe_n <= 1'b1;
         o_sram_we_n <= 1'b1;
      end
      else
      begin
         phase <= {phase[2:0], i_start};
         if (i_start)
         begin
            o_sram_ce_n <= 1'b0;
            o_sram_oe_n <= i_write;
            o_sram_we_n <= ~i_write;
         end
         else if (phase[3])
         begin
            o_sram_ce_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            o_sram_we_n <= 1'b1;
         end
      end
   end

   // address and data held for the whole access
   always_ff @(posedge clk)
   begin
      if (i_start)
      begin
         o_sram_a    <= i_addr;
         o_sram1_out <= i_wdata[WORD_W-1:HALF_W];
         o_sram2_out <= i_wdata[HALF_W-1:0];
      end
      // both halves land together, valid during done
      if (phase[2])
         rdata_q <= {i_sram1_in, i_sram2_in};
   end

   assign o_done  = phase[3];
   assign o_rdata = rdata_q;

endmodule

/* hdl/ram_controller_top.sv */
// SRAM memory controller top level: microcode and data ports, arbiter and sequencer
`timescale 1ns/100ps

module ram_controller_top #(
   parameter int DATA_AW = 22
) (
   input  logic                              clk,
   input  logic                              reset,
   // microcode client
   input  logic                              i_mcr_rd_req,
   input  logic                              i_mcr_wr_req,
   input  logic [sram_ctrl_pkg::MCR_AW-1:0]  i_mcr_addr,
   input  logic [sram_ctrl_pkg::MCR_W-1:0]   i_mcr_wdata,
   output logic [sram_ctrl_pkg::MCR_W-1:0]   o_mcr_rdata,
   output logic                              o_mcr_ready,
   output logic                              o_mcr_done,
   // data memory client
   input  logic                              i_data_rd_req,
   input  logic                              i_data_wr_req,
   input  logic [DATA_AW-1:0]                i_data_addr,
   input  logic [sram_ctrl_pkg::WORD_W-1:0]  i_data_wdata,
   output logic [sram_ctrl_pkg::WORD_W-1:0]  o_data_rdata,
   output logic                              o_data_ready,
   output logic                              o_data_done,
   // SRAM pins
   output logic [sram_ctrl_pkg::SRAM_AW-1:0] o_sram_a,
   output logic                              o_sram_oe_n,
   output logic                              o_sram_we_n,
   output logic                              o_sram_ce_n,
   input  logic [sram_ctrl_pkg::HALF_W-1:0]  i_sram1_in,
   input  logic [sram_ctrl_pkg::HALF_W-1:0]  i_sram2_in,
   output logic [sram_ctrl_pkg::HALF_W-1:0]  o_sram1_out,
   output logic [sram_ctrl_pkg::HALF_W-1:0]  o_sram2_out
);
   import sram_ctrl_pkg::*;

   logic                   mcr_acc_req;
   logic                   mcr_acc_write;
   logic [MCR_AW-1:0]      mcr_acc_addr;
   logic [MCR_W-1:0]       mcr_acc_wdata;
   logic                   mcr_acc_done;
   logic                   data_acc_req;
   logic                   data_acc_write;
   logic [DATA_WIN_AW-1:0] data_acc_offset;
   logic [WORD_W-1:0]      data_acc_wdata;
   logic                   data_acc_done;
   logic [WORD_W-1:0]      acc_rdata;
   logic                   seq_start;
   sram_addr_u             seq_addr;
   logic                   seq_write;
   logic [WORD_W-1:0]      seq_wdata;
   logic                   seq_done;
   logic [WORD_W-1:0]      seq_rdata;

   mcr_port i_mcr_port (
      .clk         (clk),
      .reset       (reset),
      .i_mcr_rd_req(i_mcr_rd_req),
      .i_mcr_wr_req(i_mcr_wr_req),
      .i_mcr_addr  (i_mcr_addr),
      .i_mcr_wdata (i_mcr_wdata),
      .i_acc_done  (mcr_acc_done),
      .i_acc_rdata (acc_rdata),
      .o_mcr_rdata (o_mcr_rdata),
      .o_mcr_ready (o_mcr_ready),
      .o_mcr_done  (o_mcr_done),
      .o_acc_req   (mcr_acc_req),
      .o_acc_write (mcr_acc_write),
      .o_acc_addr  (mcr_acc_addr),
      .o_acc_wdata (mcr_acc_wdata)
   );

   data_port #(
      .DATA_AW(DATA_AW)
   ) i_data_port (
      .clk          (clk),
      .reset        (reset),
      .i_data_rd_req(i_data_rd_req),
      .i_data_wr_req(i_data_wr_req),
      .i_data_addr  (i_data_addr),
      .i_data_wdata (i_data_wdata),
      .i_acc_done   (data_acc_done),
      .i_acc_rdata  (acc_rdata),
      .o_data_rdata (o_data_rdata),
      .o_data_ready (o_data_ready),
      .o_data_done  (o_data_done),
      .o_acc_req    (data_acc_req),
      .o_acc_write  (data_acc_write),
      .o_acc_offset (data_acc_offset),
      .o_acc_wdata  (data_acc_wdata)
   );

   sram_arbiter i_sram_arbiter (
      .clk              (clk),
      .reset            (reset),
      .i_mcr_acc_req    (mcr_acc_req),
      .i_mcr_acc_write  (mcr_acc_write),
      .i_mcr_acc_addr   (mcr_acc_addr),
      .i_mcr_acc_wdata  (mcr_acc_wdata),
      .o_mcr_acc_done   (mcr_acc_done),
      .i_data_acc_req   (data_acc_req),
      .i_data_acc_write (data_acc_write),
      .i_data_acc_offset(data_acc_offset),
      .i_data_acc_wdata (data_acc_wdata),
      .o_data_acc_done  (data_acc_done),
      .o_acc_rdata      (acc_rdata),
      .o_start          (seq_start),
      .o_addr           (seq_addr),
      .o_write          (seq_write),
      .o_wdata          (seq_wdata),
      .i_done           (seq_done),
      .i_rdata          (seq_rdata)
   );

   sram_sequencer i_sram_sequencer (
      .clk        (clk),
      .reset      (reset),
      .i_start    (seq_start),
      .i_addr     (seq_addr),
      .i_write    (seq_write),
      .i_wdata    (seq_wdata),
      .i_sram1_in (i_sram1_in),
      .i_sram2_in (i_sram2_in),
      .o_done     (seq_done),
      .o_rdata    (seq_rdata),
      .o_sram_a   (o_sram_a),
      .o_sram_oe_n(o_sram_oe_n),
      .o_sram_we_n(o_sram_we_n),
      .o_sram_ce_n(o_sram_ce_n),
      .o_sram1_out(o_sram1_out),
      .o_sram2_out(o_sram2_out)
   );

endmodule

/* verif/sram_model.sv */
// behavioral asynchronous SRAM, two 16-bit halves on one address and control set
`timescale 1ns/100ps

module sram_model (
   input  logic [sram_ctrl_pkg::SRAM_AW-1:0] i_sram_a,
   input  logic                              i_sram_ce_n,
   input  logic                              i_sram_oe_n,
   input  logic                              i_sram_we_n,
   input  logic [sram_ctrl_pkg::HALF_W-1:0]  i_half1,
   input  logic [sram_ctrl_pkg::HALF_W-1:0]  i_half2,
   output logic [sram_ctrl_pkg::HALF_W-1:0]  o_half1,
   output logic [sram_ctrl_pkg::HALF_W-1:0]  o_half2
);
   import sram_ctrl_pkg::*;

   logic [HALF_W-1:0] mem1 [2**SRAM_AW];
   logic [HALF_W-1:0] mem2 [2**SRAM_AW];
   logic              armed;

   initial
      armed = 1'b0;

   // a write pulse has started
   always @(negedge i_sram_we_n)
      armed = 1'b1;

   // write lands at the end of the pulse, address and data are still held
   always @(posedge i_sram_we_n)
   begin
      if (armed)
      begin
         mem1[i_sram_a] = i_half1;
         mem2[i_sram_a] = i_half2;
      end
      armed = 1'b0;
   end

   // outputs only valid while chip and output enable are low
   assign o_half1 = (!i_sram_ce_n && !i_sram_oe_n) ? mem1[i_sram_a] : 'x;
   assign o_half2 = (!i_sram_ce_n && !i_sram_oe_n) ? mem2[i_sram_a] : 'x;

endmodule

/* verif/clock_gen.sv */
// testbench clock and synchronous active-high reset
`timescale 1ns/100ps

module clock_gen #(
   parameter int PERIOD       = 40,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD / 2) clk = ~clk;
   end

   // reset held for a fixed number of rising edges
   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* verif/ram_controller_asserts.sv */
// concurrent checks on SRAM control pins and client handshakes, bound into the controller top
`timescale 1ns/100ps

module ram_controller_asserts (
   input logic clk,
   input logic reset,
   input logic i_sram_ce_n,
   input logic i_sram_oe_n,
   input logic i_sram_we_n,
   input logic i_mcr_ready,
   input logic i_mcr_done,
   input logic i_data_ready,
   input logic i_data_done
);

   // read and write never overlap on the pins
   a_oe_we_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(!i_sram_oe_n && !i_sram_we_n))
      else $error("SRAM output enable and write enable are both active");

   a_ce_with_enable: assert property (@(posedge clk) disable iff (reset)
      (!i_sram_oe_n || !i_sram_we_n) |-> !i_sram_ce_n)
      else $error("SRAM enable active while chip enable is high");

   // one response kind per client
   a_mcr_resp: assert property (@(posedge clk) disable iff (reset)
      !(i_mcr_ready && i_mcr_done))
      else $error("microcode ready and done are high together");

   a_data_resp: assert property (@(posedge clk) disable iff (reset)
      !(i_data_ready && i_data_done))
      else $error("data ready and done are high together");

endmodule

bind ram_controller_top ram_controller_asserts i_asserts (
   .clk         (clk),
   .reset       (reset),
   .i_sram_ce_n (o_sram_ce_n),
   .i_sram_oe_n (o_sram_oe_n),
   .i_sram_we_n (o_sram_we_n),
   .i_mcr_ready (o_mcr_ready),
   .i_mcr_done  (o_mcr_done),
   .i_data_ready(o_data_ready),
   .i_data_done (o_data_done)
);

/* verif/tb_ram_controller.sv */
// testbench top for the SRAM controller: transfer table, reference memories, watchdog
`timescale 1ns/100ps

module tb_ram_controller;
   import sram_ctrl_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int DATA_AW      = 22;
   localparam int N_ENTRIES    = 17;
   localparam int TXN_CYCLES   = 40;
   localparam int WAIT_LIMIT   = 64;
   localparam int HOLD_CYCLES  = 3;
   localparam int WATCHDOG_NS  = (N_ENTRIES + RESET_CYCLES + 2) * TXN_CYCLES * CLK_PERIOD;

   localparam logic [1:0] CL_MCR  = 2'd0;
   localparam logic [1:0] CL_DATA = 2'd1;
   localparam logic [1:0] CL_BOTH = 2'd2;

   // client, write, address, data seed
   localparam logic [40:0] TRANSFERS [N_ENTRIES] = '{
      {CL_MCR,  1'b1, 22'h000123, 16'h0001},
      {CL_MCR,  1'b0, 22'h000123, 16'h0000},
      {CL_MCR,  1'b1, 22'h003ffe, 16'h0002},
      {CL_MCR,  1'b0, 22'h003ffe, 16'h0000},
      // offset equals the high half address of the first microcode word below the tag
      {CL_DATA, 1'b1, 22'h000246, 16'h0003},
      {CL_MCR,  1'b0, 22'h000123, 16'h0000},
      {CL_DATA, 1'b0, 22'h000246, 16'h0000},
      {CL_DATA, 1'b1, 22'h01abcd, 16'h0004},
      {CL_DATA, 1'b0, 22'h01abcd, 16'h0000},
      // above the window, then a write aliasing onto offset 0x00456
      {CL_DATA, 1'b0, 22'h3e0123, 16'h0000},
      {CL_DATA, 1'b1, 22'h260456, 16'h0005},
      {CL_DATA, 1'b0, 22'h000456, 16'h0000},
      {CL_BOTH, 1'b1, 22'h000777, 16'h0006},
      {CL_BOTH, 1'b0, 22'h000777, 16'h0000},
      // high half of this word sits at 0x00456 below the tag
      {CL_MCR,  1'b1, 22'h00022b, 16'h0007},
      {CL_DATA, 1'b0, 22'h000456, 16'h0000},
      {CL_MCR,  1'b0, 22'h00022b, 16'h0000}
   };

   logic                clk;
   logic                reset;
   logic                mcr_rd_req;
   logic                mcr_wr_req;
   logic [MCR_AW-1:0]   mcr_addr;
   logic [MCR_W-1:0]    mcr_wdata;
   logic [MCR_W-1:0]    mcr_rdata;
   logic                mcr_ready;
   logic                mcr_done;
   logic                data_rd_req;
   logic                data_wr_req;
   logic [DATA_AW-1:0]  data_addr;
   logic [WORD_W-1:0]   data_wdata;
   logic [WORD_W-1:0]   data_rdata;
   logic                data_ready;
   logic                data_done;
   logic [SRAM_AW-1:0]  sram_a;
   logic                sram_oe_n;
   logic                sram_we_n;
   logic                sram_ce_n;
   logic [HALF_W-1:0]   sram1_in;
   logic [HALF_W-1:0]   sram2_in;
   logic [HALF_W-1:0]   sram1_out;
   logic [HALF_W-1:0]   sram2_out;

   // reference contents per client, indexed by client address
   logic [MCR_W-1:0]    mcr_ref  [2**MCR_AW];
   logic [WORD_W-1:0]   data_ref [2**DATA_WIN_AW];

   int errors = 0;
   int checks = 0;

   clock_gen #(
      .PERIOD      (CLK_PERIOD),
      .RESET_CYCLES(RESET_CYCLES)
   ) i_clock_gen (
      .clk  (clk),
      .reset(reset)
   );

   ram_controller_top #(
      .DATA_AW(DATA_AW)
   ) i_dut (
      .clk          (clk),
      .reset        (reset),
      .i_mcr_rd_req (mcr_rd_req),
      .i_mcr_wr_req (mcr_wr_req),
      .i_mcr_addr   (mcr_addr),
      .i_mcr_wdata  (mcr_wdata),
      .o_mcr_rdata  (mcr_rdata),
      .o_mcr_ready  (mcr_ready),
      .o_mcr_done   (mcr_done),
      .i_data_rd_req(data_rd_req),
      .i_data_wr_req(data_wr_req),
      .i_data_addr  (data_addr),
      .i_data_wdata (data_wdata),
      .o_data_rdata (data_rdata),
      .o_data_ready (data_ready),
      .o_data_done  (data_done),
      .o_sram_a     (sram_a),
      .o_sram_oe_n  (sram_oe_n),
      .o_sram_we_n  (sram_we_n),
      .o_sram_ce_n  (sram_ce_n),
      .i_sram1_in   (sram1_in),
      .i_sram2_in   (sram2_in),
      .o_sram1_out  (sram1_out),
      .o_sram2_out  (sram2_out)
   );

   sram_model i_sram (
      .i_sram_a   (sram_a),
      .i_sram_ce_n(sram_ce_n),
      .i_sram_oe_n(sram_oe_n),
      .i_sram_we_n(sram_we_n),
      .i_half1    (sram1_out),
      .i_half2    (sram2_out),
      .o_half1    (sram1_in),
      .o_half2    (sram2_in)
   );

   // ------------------------------------------------------------------------
   // helpers

   function automatic logic [31:0] next_random(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic flag_error(input string msg);
      $display("ERROR %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic mcr_transfer(input logic write, input logic [MCR_AW-1:0] addr,
                               input logic [MCR_W-1:0] wdata,
                               output logic [MCR_W-1:0] rdata);
      int n;
      @(posedge clk);
      mcr_addr   <= addr;
      mcr_wdata  <= wdata;
      mcr_rd_req <= !write;
      mcr_wr_req <= write;
      n = 0;
      @(negedge clk);
      while (!(mcr_ready || mcr_done) && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= WAIT_LIMIT)
      begin
         $display("microcode port gave no ready or done within %0d cycles", WAIT_LIMIT);
         errors++;
      end
      rdata = mcr_rdata;
      checks++;
      assert (mcr_done == write && mcr_ready == !write)
      else
         flag_error("microcode port raised the wrong one of ready and done");
      // response has to stay up while the request is held
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk);
         checks++;
         assert (mcr_ready || mcr_done)
         else
            flag_error("microcode ready or done dropped before the request");
      end
      @(posedge clk);
      mcr_rd_req <= 1'b0;
      mcr_wr_req <= 1'b0;
      repeat (2) @(negedge clk);
      checks++;
      assert (!mcr_ready && !mcr_done)
      else
         flag_error("microcode ready or done still high after release");
   endtask

   task automatic data_transfer(input logic write, input logic [DATA_AW-1:0] addr,
                                input logic [WORD_W-1:0] wdata,
                                output logic [WORD_W-1:0] rdata);
      int n;
      @(posedge clk);
      data_addr   <= addr;
      data_wdata  <= wdata;
      data_rd_req <= !write;
      data_wr_req <= write;
      n = 0;
      @(negedge clk);
      while (!(data_ready || data_done) && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (n >= WAIT_LIMIT)
      begin
         $display("data port gave no ready or done within %0d cycles", WAIT_LIMIT);
         errors++;
      end
      rdata = data_rdata;
      checks++;
      assert (data_done == write && data_ready == !write)
      else
         flag_error("data port raised the wrong one of ready and done");
      repeat (HOLD_CYCLES)
      begin
         @(negedge clk);
         checks++;
         assert (data_ready || data_done)
         else
            flag_error("data ready or done dropped before the request");
      end
      @(posedge clk);
      data_rd_req <= 1'b0;
      data_wr_req <= 1'b0;
      repeat (2) @(negedge clk);
      checks++;
      assert (!data_ready && !data_done)
      else
         flag_error("data ready or done still high after release");
   endtask

   // SRAM control pins on every cycle out of reset
   always @(negedge clk)
   begin
      if (!reset)
      begin
         assert (sram_oe_n || sram_we_n)
         else
            flag_error("SRAM output enable and write enable low together");
         assert ((sram_oe_n && sram_we_n) || !sram_ce_n)
         else
            flag_error("SRAM enable low while chip enable is high");
      end
   end

   // ------------------------------------------------------------------------
   // watchdog

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, a transfer never finished", WATCHDOG_NS);
      $display("tests failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // main sequence

   initial
   begin
      logic [1:0]             client;
      logic                   write;
      logic [DATA_AW-1:0]     addr;
      logic [15:0]            seed;
      logic [31:0]            rng;
      logic [31:0]            w0;
      logic [MCR_W-1:0]       mcr_word;
      logic [MCR_W-1:0]       mcr_got;
      logic [WORD_W-1:0]      data_word;
      logic [WORD_W-1:0]      data_got;
      logic [WORD_W-1:0]      data_exp;
      logic [DATA_WIN_AW-1:0] offset;

      mcr_rd_req  = 1'b0;
      mcr_wr_req  = 1'b0;
      mcr_addr    = '0;
      mcr_wdata   = '0;
      data_rd_req = 1'b0;
      data_wr_req = 1'b0;
      data_addr   = '0;
      data_wdata  = '0;
      rng         = 32'h487d;

      @(negedge reset);
      @(negedge clk);
      checks++;
      assert (sram_ce_n && sram_oe_n && sram_we_n)
      else
         flag_error("SRAM controls not inactive after reset");
      checks++;
      assert (!mcr_ready && !mcr_done && !data_ready && !data_done)
      else
         flag_error("ready or done high after reset");

      for (int i = 0; i < N_ENTRIES; i++)
      begin
         {client, write, addr, seed} = TRANSFERS[i];
         offset    = addr[DATA_WIN_AW-1:0];
         mcr_word  = '0;
         data_word = '0;
         // bit 48 follows the seed parity so both values get exercised
         if (write && client != CL_DATA)
         begin
            rng      = next_random(rng ^ {16'h0000, seed});
            w0       = rng;
            rng      = next_random(rng);
            mcr_word = {seed[0], w0[15:0], rng};
         end
         if (write && client != CL_MCR)
         begin
            rng       = next_random(rng ^ {16'h0000, seed});
            data_word = rng;
         end

         fork
            if (client != CL_DATA)
               mcr_transfer(write, addr[MCR_AW-1:0], mcr_word, mcr_got);
            if (client != CL_MCR)
               data_transfer(write, addr, data_word, data_got);
         join

         if (client != CL_DATA)
         begin
            if (write)
               mcr_ref[addr[MCR_AW-1:0]] = mcr_word;
            else
            begin
               checks++;
               assert (mcr_got == mcr_ref[addr[MCR_AW-1:0]])
               else
                  flag_error($sformatf("microcode read at %h gave %h, expected %h",
                                       addr[MCR_AW-1:0], mcr_got, mcr_ref[addr[MCR_AW-1:0]]));
            end
         end

         if (client != CL_MCR)
         begin
            // writes above the window alias onto the offset
            if (write)
               data_ref[offset] = data_word;
            else
            begin
               data_exp = (addr[DATA_AW-1:DATA_WIN_AW] == '0) ? data_ref[offset] : '1;
               checks++;
               assert (data_got == data_exp)
               else
                  flag_error($sformatf("data read at %h gave %h, expected %h",
                                       addr, data_got, data_exp));
            end
         end
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

/* src.f */
hdl/sram_ctrl_pkg.sv
hdl/mcr_port.sv
hdl/data_port.sv
hdl/sram_arbiter.sv
hdl/sram_sequencer.sv
hdl/ram_controller_top.sv
verif/sram_model.sv
verif/clock_gen.sv
verif/ram_controller_asserts.sv
verif/tb_ram_controller.sv

/* Makefile */
# Verilator build, run and lint for the SRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_ram_controller
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= all tests passed
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line in the simulator output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
